/* rtl/cpu_isa_pkg.sv */
/*
 * cpu isa definitions
 * data word, register index, opcode set and the packed instruction view,
 * plus helpers that recover the immediate and jump target fields
 */
`default_nettype none

package cpu_isa_pkg;

	// signed 16-bit data word
	typedef logic signed [15:0] word_t;

	// one of sixteen registers
	typedef logic [3:0] reg_idx_t;

	// instruction or data word address inside the 4 KB window
	typedef logic [10:0] word_addr_t;

	// 3-bit major opcode
	typedef enum logic [2:0] {
		OP_ARITH  = 3'b000,
		OP_CMPMUL = 3'b001,
		OP_LOAD   = 3'b010,
		OP_STORE  = 3'b011,
		OP_BEQ    = 3'b100,
		OP_JUMP   = 3'b101
	} opcode_e;

	// r-type layout, msb first
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic     func;
	} instr_t;

	// 5-bit signed immediate sits on top of rd and func
	function automatic logic signed [4:0] imm_of(instr_t i);
		return {i.rd, i.func};
	endfunction

	// jump target is instruction bits 11 down to 1
	function automatic word_addr_t target_of(instr_t i);
		return {i.rs[2:0], i.rt, i.rd};
	endfunction

endpackage

`default_nettype wire

/* rtl/cpu_mem_pkg.sv */
/*
 * cpu memory map
 * bus address width and the default base of the 4 KB memory window
 */
`default_nettype none

package cpu_mem_pkg;

	// byte address width on the bus
	localparam int BUS_ADDR_W = 16;

	// byte address as seen by the memory
	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

	// window base, byte address = base + 2 * word address
	localparam bus_addr_t MEM_BASE_DEFAULT = 16'h1000;

endpackage

`default_nettype wire

/* rtl/mem_req_if.sv */
/*
 * memory request channel
 * one outstanding single-word access from the controller to the bus master
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
	import cpu_isa_pkg::*;

	// one-cycle start pulse
	logic       req;
	// high for a store
	logic       we;
	// held until done
	word_addr_t addr;
	// read result, valid from done until the next req
	word_t      rdata;
	// one-cycle completion pulse
	logic       done;

	modport requester (output req, we, addr, input rdata, done);
	modport servant (input req, we, addr, output rdata, done);

endinterface

`default_nettype wire

/* rtl/cpu_control.sv */
/*
 * multi-cycle controller
 * walks fetch, decode, execute, memory and write-back states,
 * holds the instruction register and drives the busy flag io_stall
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
	input  logic                    clk,
	input  logic                    rst_n,
	input  cpu_isa_pkg::word_addr_t pc,
	input  cpu_isa_pkg::word_t      alu_result,
	output cpu_isa_pkg::instr_t     instr,
	output logic                    decode_en,
	output logic                    exec_en,
	output logic                    wr_en,
	output cpu_isa_pkg::reg_idx_t   wr_idx,
	output logic                    wr_from_mem,
	output logic                    io_stall,
	mem_req_if.requester            mem
);
	import cpu_isa_pkg::*;

	typedef enum logic [2:0] {
		IDLE, FETCH, DECODE, EXECUTE, WB_RD, MEM_LOAD, WB_RT, MEM_STORE
	} state_e;

	state_e state;
	state_e next_state;
	// a request is in flight on mem
	logic   pending;
	logic   mem_state;

	// ----------------------------------------
	// state register and next state
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:    next_state = FETCH;
			FETCH: begin
				if (mem.done) begin
					next_state = DECODE;
				end
			end
			DECODE:  next_state = EXECUTE;
			EXECUTE: begin
				case (instr.opcode)
					OP_ARITH, OP_CMPMUL: next_state = WB_RD;
					OP_LOAD:             next_state = MEM_LOAD;
					OP_STORE:            next_state = MEM_STORE;
					// beq and jump finish here
					default:             next_state = FETCH;
				endcase
			end
			MEM_LOAD: begin
				if (mem.done) begin
					next_state = WB_RT;
				end
			end
			MEM_STORE: begin
				if (mem.done) begin
					next_state = FETCH;
				end
			end
			WB_RD, WB_RT: next_state = FETCH;
			default: next_state = IDLE;
		endcase
	end

	// ----------------------------------------
	// memory requests
	// ----------------------------------------
	assign mem_state = (state == FETCH) || (state == MEM_LOAD) || (state == MEM_STORE);

	// first cycle of each access state fires req
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (mem.done) begin
			pending <= 1'b0;
		end else if (mem.req) begin
			pending <= 1'b1;
		end
	end

	assign mem.req  = mem_state && !pending;
	assign mem.we   = (state == MEM_STORE);
	// pc for fetch, computed data address otherwise
	assign mem.addr = (state == FETCH) ? pc : word_addr_t'(alu_result[10:0]);

	// instruction register
	always_ff @(posedge clk) begin
		if (state == FETCH && mem.done) begin
			instr <= instr_t'(mem.rdata);
		end
	end

	// unit strobes
	assign decode_en   = (state == DECODE);
	assign exec_en     = (state == EXECUTE);
	assign wr_en       = (state == WB_RD) || (state == WB_RT);
	assign wr_from_mem = (state == WB_RT);
	// load writes rt, arithmetic writes rd
	assign wr_idx      = wr_from_mem ? instr.rt : instr.rd;

	// low on the first fetch cycle after a finished instruction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_stall <= 1'b1;
		end else begin
			io_stall <= !(next_state == FETCH && state != FETCH && state != IDLE);
		end
	end

endmodule

`default_nettype wire

/* rtl/pc_unit.sv */
/*
 * program counter
 * steps by one per instruction, takes beq offsets and jump targets
 */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    exec_en,
	input  cpu_isa_pkg::instr_t     instr,
	input  cpu_isa_pkg::word_t      rs_data,
	input  cpu_isa_pkg::word_t      rt_data,
	output cpu_isa_pkg::word_addr_t pc
);
	import cpu_isa_pkg::*;

	logic signed [4:0] imm;
	word_addr_t        imm_ext;

	assign imm     = imm_of(instr);
	// sign extend to word address width
	assign imm_ext = {{6{imm[4]}}, imm};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (exec_en) begin
			if (instr.opcode == OP_JUMP) begin
				pc <= target_of(instr);
			end else if (instr.opcode == OP_BEQ && rs_data == rt_data) begin
				pc <= pc + 11'd1 + imm_ext;
			end else begin
				pc <= pc + 11'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
/*
 * register file
 * sixteen 16-bit registers, source reads latched in decode,
 * write-back from either the alu or the load data
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  decode_en,
	input  cpu_isa_pkg::instr_t   instr,
	input  logic                  wr_en,
	input  cpu_isa_pkg::reg_idx_t wr_idx,
	input  logic                  wr_from_mem,
	input  cpu_isa_pkg::word_t    alu_result,
	input  cpu_isa_pkg::word_t    mem_rdata,
	output cpu_isa_pkg::word_t    rs_data,
	output cpu_isa_pkg::word_t    rt_data
);
	import cpu_isa_pkg::*;

	word_t regs [16];

	// write port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_from_mem ? mem_rdata : alu_result;
		end
	end

	// source operands held through execute and memory
	always_ff @(posedge clk) begin
		if (decode_en) begin
			rs_data <= regs[instr.rs];
			rt_data <= regs[instr.rt];
		end
	end

endmodule

`default_nettype wire

/* rtl/alu.sv */
/*
 * execute unit
 * add, sub, set-less-than, mult and load/store address sum
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic                clk,
	input  logic                exec_en,
	input  cpu_isa_pkg::instr_t instr,
	input  cpu_isa_pkg::word_t  rs_data,
	input  cpu_isa_pkg::word_t  rt_data,
	output cpu_isa_pkg::word_t  result
);
	import cpu_isa_pkg::*;

	logic signed [4:0] imm;
	word_t             imm_ext;

	assign imm     = imm_of(instr);
	assign imm_ext = {{11{imm[4]}}, imm};

	always_ff @(posedge clk) begin
		if (exec_en) begin
			case (instr.opcode)
				// func selects sub
				OP_ARITH:  result <= instr.func ? rs_data - rt_data : rs_data + rt_data;
				// func selects mult, product keeps low 16 bits
				OP_CMPMUL: result <= instr.func ? rs_data * rt_data
				                                : ((rs_data < rt_data) ? 16'sd1 : 16'sd0);
				// data word address
				OP_LOAD, OP_STORE: result <= rs_data + imm_ext;
				default: result <= result;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/bus_master.sv */
/*
 * single-beat axi-style bus master
 * turns one mem request into a read or a write on valid/ready channels,
 * forms the byte address and registers read data
 */
`timescale 1ns/1ps
`default_nettype none

module bus_master #(
	parameter cpu_mem_pkg::bus_addr_t MEM_BASE = cpu_mem_pkg::MEM_BASE_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cpu_isa_pkg::word_t     wdata_in,
	input  logic                   arready,
	input  cpu_isa_pkg::word_t     rdata,
	input  logic                   rvalid,
	input  logic                   awready,
	input  logic                   bvalid,
	output cpu_mem_pkg::bus_addr_t araddr,
	output logic                   arvalid,
	output logic                   rready,
	output cpu_mem_pkg::bus_addr_t awaddr,
	output cpu_isa_pkg::word_t     wdata,
	output logic                   awvalid,
	output logic                   bready,
	mem_req_if.servant             mem
);
	import cpu_isa_pkg::*;
	import cpu_mem_pkg::*;

	bus_addr_t byte_addr;
	word_t     wdata_q;
	word_t     rdata_q;

	// ----------------------------------------
	// request payload
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (mem.req) begin
			byte_addr <= MEM_BASE + bus_addr_t'({mem.addr, 1'b0});
			if (mem.we) begin
				wdata_q <= wdata_in;
			end
		end
	end

	assign araddr = byte_addr;
	assign awaddr = byte_addr;
	assign wdata  = wdata_q;

	// ----------------------------------------
	// read channel
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arvalid <= 1'b0;
			rready  <= 1'b0;
		end else begin
			// address held until accepted
			if (arvalid && arready) begin
				arvalid <= 1'b0;
			end else if (mem.req && !mem.we) begin
				arvalid <= 1'b1;
			end
			if (rready && rvalid) begin
				rready <= 1'b0;
			end else if (arvalid && arready) begin
				rready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rready && rvalid) begin
			rdata_q <= rdata;
		end
	end

	assign mem.rdata = rdata_q;

	// ----------------------------------------
	// write channel, address and data together
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awvalid <= 1'b0;
			bready  <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				awvalid <= 1'b0;
			end else if (mem.req && mem.we) begin
				awvalid <= 1'b1;
			end
			// wait for the write response
			if (bready && bvalid) begin
				bready <= 1'b0;
			end else if (awvalid && awready) begin
				bready <= 1'b1;
			end
		end
	end

	// completion one cycle after the last handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem.done <= 1'b0;
		end else begin
			mem.done <= (rready && rvalid) || (bready && bvalid);
		end
	end

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
/*
 * 16-bit multi-cycle cpu core
 * controller, pc, register file, alu and bus master on plain bus ports
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter cpu_mem_pkg::bus_addr_t MEM_BASE = cpu_mem_pkg::MEM_BASE_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   io_stall,
	// read address and data
	output cpu_mem_pkg::bus_addr_t araddr,
	output logic                   arvalid,
	input  logic                   arready,
	input  cpu_isa_pkg::word_t     rdata,
	input  logic                   rvalid,
	output logic                   rready,
	// write address with data, then response
	output cpu_mem_pkg::bus_addr_t awaddr,
	output cpu_isa_pkg::word_t     wdata,
	output logic                   awvalid,
	input  logic                   awready,
	input  logic                   bvalid,
	output logic                   bready
);
	import cpu_isa_pkg::*;

	instr_t     instr;
	word_addr_t pc;
	word_t      rs_data;
	word_t      rt_data;
	word_t      alu_result;
	logic       decode_en;
	logic       exec_en;
	logic       wr_en;
	reg_idx_t   wr_idx;
	logic       wr_from_mem;

	mem_req_if mem_bus ();

	// ----------------------------------------
	// control and datapath
	// ----------------------------------------
	cpu_control u_control (
		.clk(clk), .rst_n(rst_n), .pc(pc), .alu_result(alu_result),
		.instr(instr), .decode_en(decode_en), .exec_en(exec_en), .wr_en(wr_en),
		.wr_idx(wr_idx), .wr_from_mem(wr_from_mem), .io_stall(io_stall), .mem(mem_bus)
	);

	pc_unit u_pc (
		.clk(clk), .rst_n(rst_n), .exec_en(exec_en), .instr(instr),
		.rs_data(rs_data), .rt_data(rt_data), .pc(pc)
	);

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n), .decode_en(decode_en), .instr(instr),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_from_mem(wr_from_mem),
		.alu_result(alu_result), .mem_rdata(mem_bus.rdata),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	alu u_alu (
		.clk(clk), .exec_en(exec_en), .instr(instr),
		.rs_data(rs_data), .rt_data(rt_data), .result(alu_result)
	);

	// store data comes from the rt operand
	bus_master #(.MEM_BASE(MEM_BASE)) u_bus (
		.clk(clk), .rst_n(rst_n), .wdata_in(rt_data),
		.arready(arready), .rdata(rdata), .rvalid(rvalid), .awready(awready),
		.bvalid(bvalid), .araddr(araddr), .arvalid(arvalid), .rready(rready),
		.awaddr(awaddr), .wdata(wdata), .awvalid(awvalid), .bready(bready),
		.mem(mem_bus)
	);

endmodule

`default_nettype wire

/* bench/cpu_top_assert.sv */
/*
 * bus protocol checker for the cpu core
 * valid signals hold with stable payload until accepted,
 * response readies hold until the response, io_stall pulses last one cycle
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_top_assert (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   io_stall,
	input cpu_mem_pkg::bus_addr_t araddr,
	input logic                   arvalid,
	input logic                   arready,
	input logic                   rvalid,
	input logic                   rready,
	input cpu_mem_pkg::bus_addr_t awaddr,
	input cpu_isa_pkg::word_t     wdata,
	input logic                   awvalid,
	input logic                   awready,
	input logic                   bvalid,
	input logic                   bready
);
	// failures seen so far, read by the testbench report
	int fail_count = 0;

	// read address held until arready
	assert property (@(posedge clk) disable iff (!rst_n)
			(arvalid && !arready) |=> (arvalid && $stable(araddr)))
		else begin
			$error("read address dropped or changed before arready");
			fail_count++;
		end

	// write address and data travel together and hold until awready
	assert property (@(posedge clk) disable iff (!rst_n)
			(awvalid && !awready) |=> (awvalid && $stable(awaddr) && $stable(wdata)))
		else begin
			$error("write address or data dropped or changed before awready");
			fail_count++;
		end

	// rready waits for rvalid
	assert property (@(posedge clk) disable iff (!rst_n)
			(rready && !rvalid) |=> rready)
		else begin
			$error("rready dropped before rvalid");
			fail_count++;
		end

	// bready waits for bvalid
	assert property (@(posedge clk) disable iff (!rst_n)
			(bready && !bvalid) |=> bready)
		else begin
			$error("bready dropped before bvalid");
			fail_count++;
		end

	// one low cycle per finished instruction
	assert property (@(posedge clk) disable iff (!rst_n)
			!io_stall |=> io_stall)
		else begin
			$error("io_stall low for two cycles in a row");
			fail_count++;
		end

endmodule

`default_nettype wire

/* bench/cpu_top_tb.sv */
/*
 * testbench for the cpu core
 * memory model with random bus delays, a reference run of the program
 * that predicts every bus transfer, value assertions and the final report
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_top_tb;
	import cpu_mem_pkg::*;

	localparam bus_addr_t  MEM_BASE  = MEM_BASE_DEFAULT;
	localparam int         MAX_DELAY = 3;
	localparam logic [2:0] ARITH     = 3'd0;
	localparam logic [2:0] CMPMUL    = 3'd1;
	localparam logic [2:0] LOAD      = 3'd2;
	localparam logic [2:0] STORE     = 3'd3;
	localparam logic [2:0] BEQ       = 3'd4;

	logic        clk;
	logic        rst_n;
	logic        io_stall;
	logic [15:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [15:0] rdata;
	logic        rvalid;
	logic        rready;
	logic [15:0] awaddr;
	logic [15:0] wdata;
	logic        awvalid;
	logic        awready;
	logic        bvalid;
	logic        bready;

	// bus memory and its copy for the reference run
	logic [15:0] mem [2048];
	logic [15:0] ref_mem [2048];
	logic [31:0] lcg_state;

	// predicted transfers with each read tagged by its test
	bus_addr_t   rd_addr_q [$];
	int          rd_test_q [$];
	bus_addr_t   wr_addr_q [$];
	logic [15:0] wr_data_q [$];
	int          n_instr;
	int          n_reads;
	int          n_writes;
	int          rd_count = 0;
	int          wr_count = 0;
	int          stall_pulses = 0;
	int          cycles = 0;
	int          cycle_limit = 1000000;
	int          hits [1:6];
	int          errs [1:6];

	// expectation for the next handshake on each channel
	bus_addr_t   exp_araddr;
	int          exp_rtest = 1;
	logic        rd_live = 1'b0;
	bus_addr_t   exp_awaddr;
	logic [15:0] exp_wdata;
	logic        wr_live = 1'b0;
	logic        end_check = 1'b0;

	// memory model state
	logic        ar_fire = 1'b0;
	logic        r_fire = 1'b0;
	logic        aw_fire = 1'b0;
	logic        b_fire = 1'b0;
	logic        r_busy = 1'b0;
	logic        b_busy = 1'b0;
	int          ar_wait = 0;
	int          r_wait = 0;
	int          aw_wait = 0;
	int          b_wait = 0;
	bus_addr_t   ar_addr;
	bus_addr_t   aw_addr;
	logic [15:0] aw_data;
	logic [15:0] r_word;

	cpu_top #(.MEM_BASE(MEM_BASE)) dut0 (.*);

	bind cpu_top cpu_top_assert u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ready or valid delay in cycles
	function automatic int bus_delay();
		logic [31:0] r;
		r = lcg_next();
		return int'(r[23:16]) % (MAX_DELAY + 1);
	endfunction

	function automatic logic [10:0] word_of(bus_addr_t a);
		bus_addr_t off;
		off = a - MEM_BASE;
		return off[11:1];
	endfunction

	function automatic logic [15:0] enc_r(logic [2:0] op, logic [3:0] rs, logic [3:0] rt,
			logic [3:0] rd, logic fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i(logic [2:0] op, logic [3:0] rs, logic [3:0] rt,
			int imm);
		logic [4:0] imm5;
		imm5 = imm[4:0];
		return {op, rs, rt, imm5};
	endfunction

	function automatic logic [15:0] enc_j(logic [10:0] target);
		return {3'b101, 1'b0, target, 1'b0};
	endfunction

	function automatic string test_name(int t);
		case (t)
			1: return "reset and first fetch";
			2: return "arithmetic store data";
			3: return "load and store addresses";
			4: return "branch-on-equal targets";
			5: return "jump targets";
			default: return "fetch order and io_stall count";
		endcase
	endfunction

	task automatic load_program();
		logic [31:0] r;
		// lcg pattern mixed with the address over the whole window
		for (int a = 0; a < 2048; a++) begin
			r = lcg_next();
			mem[a] = r[31:16] ^ a[15:0];
		end
		// r8 = 2000 as a base near the top of the window
		mem[0]  = enc_i(LOAD, 4'd0, 4'd8, -1);
		// operands from negative offsets that wrap to the window top
		mem[1]  = enc_i(LOAD, 4'd0, 4'd1, -16);
		mem[2]  = enc_i(LOAD, 4'd0, 4'd2, -15);
		mem[3]  = enc_i(LOAD, 4'd8, 4'd3, 5);
		mem[4]  = enc_i(LOAD, 4'd8, 4'd4, -3);
		mem[5]  = enc_r(ARITH, 4'd1, 4'd2, 4'd5, 1'b0);
		mem[6]  = enc_i(STORE, 4'd8, 4'd5, 0);
		mem[7]  = enc_r(ARITH, 4'd3, 4'd4, 4'd6, 1'b1);
		mem[8]  = enc_i(STORE, 4'd8, 4'd6, 1);
		mem[9]  = enc_r(CMPMUL, 4'd1, 4'd2, 4'd7, 1'b0);
		mem[10] = enc_i(STORE, 4'd8, 4'd7, 2);
		mem[11] = enc_r(CMPMUL, 4'd3, 4'd4, 4'd9, 1'b1);
		mem[12] = enc_i(STORE, 4'd8, 4'd9, 3);
		mem[13] = enc_r(CMPMUL, 4'd2, 4'd1, 4'd10, 1'b0);
		mem[14] = enc_i(STORE, 4'd8, 4'd10, 4);
		// read back the sum and take a branch over two words
		mem[15] = enc_i(LOAD, 4'd8, 4'd11, 0);
		mem[16] = enc_i(BEQ, 4'd11, 4'd5, 2);
		mem[17] = enc_i(STORE, 4'd8, 4'd0, 6);
		mem[18] = enc_r(ARITH, 4'd0, 4'd0, 4'd13, 1'b0);
		mem[19] = enc_i(BEQ, 4'd1, 4'd2, 5);
		mem[20] = enc_r(ARITH, 4'd11, 4'd1, 4'd12, 1'b1);
		mem[21] = enc_i(STORE, 4'd8, 4'd12, 7);
		mem[22] = enc_j(11'd25);
		// end of program jumps to itself
		mem[23] = enc_j(11'd23);
		mem[24] = enc_r(ARITH, 4'd0, 4'd0, 4'd14, 1'b0);
		mem[25] = enc_i(BEQ, 4'd0, 4'd0, -3);
		mem[2047] = 16'd2000;
		for (int a = 0; a < 2048; a++) begin
			ref_mem[a] = mem[a];
		end
	endtask

	// ----------------------------------------
	// reference run of the instruction set
	// ----------------------------------------
	task automatic build_trace();
		logic [15:0]        regs [16];
		logic [15:0]        ir;
		logic signed [15:0] a;
		logic signed [15:0] b;
		logic [10:0]        pc;
		logic [10:0]        npc;
		logic [10:0]        ea;
		logic [10:0]        imm;
		int                 fetch_test;
		logic               stop;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		fetch_test = 1;
		stop = 1'b0;
		n_instr = 0;
		while (!stop && n_instr < 200) begin
			rd_addr_q.push_back(MEM_BASE + {4'b0, pc, 1'b0});
			rd_test_q.push_back(fetch_test);
			ir = ref_mem[pc];
			a = regs[ir[12:9]];
			b = regs[ir[8:5]];
			imm = {{6{ir[4]}}, ir[4:0]};
			npc = pc + 11'd1;
			fetch_test = 6;
			n_instr++;
			case (ir[15:13])
				3'd0: regs[ir[4:1]] = ir[0] ? a - b : a + b;
				3'd1: regs[ir[4:1]] = ir[0] ? a * b : ((a < b) ? 16'd1 : 16'd0);
				3'd2: begin
					ea = a[10:0] + imm;
					rd_addr_q.push_back(MEM_BASE + {4'b0, ea, 1'b0});
					rd_test_q.push_back(3);
					regs[ir[8:5]] = ref_mem[ea];
				end
				3'd3: begin
					ea = a[10:0] + imm;
					wr_addr_q.push_back(MEM_BASE + {4'b0, ea, 1'b0});
					wr_data_q.push_back(b);
					ref_mem[ea] = b;
				end
				3'd4: begin
					if (a == b) begin
						npc = pc + 11'd1 + imm;
					end
					fetch_test = 4;
				end
				3'd5: begin
					npc = ir[11:1];
					fetch_test = 5;
					stop = (npc == pc);
				end
				default: ;
			endcase
			pc = npc;
		end
		// the fetch that follows the final jump
		rd_addr_q.push_back(MEM_BASE + {4'b0, pc, 1'b0});
		rd_test_q.push_back(fetch_test);
		n_reads = rd_addr_q.size();
		n_writes = wr_addr_q.size();
	endtask

	// ----------------------------------------
	// memory model driving inputs on the falling edge
	// ----------------------------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			ar_fire = 1'b0;
			r_fire  = 1'b0;
			aw_fire = 1'b0;
			b_fire  = 1'b0;
			r_busy  = 1'b0;
			b_busy  = 1'b0;
		end else begin
			if (!io_stall) begin
				stall_pulses++;
			end
			// r_fire marks read data accepted at the last rising edge
			if (r_fire) begin
				rvalid = 1'b0;
				r_busy = 1'b0;
			end else if (r_busy && !rvalid) begin
				if (r_wait == 0) begin
					rvalid = 1'b1;
					rdata  = r_word;
				end else begin
					r_wait--;
				end
			end
			// read address
			if (ar_fire) begin
				if (rd_count < n_reads) begin
					hits[rd_test_q[rd_count]]++;
				end
				rd_count++;
				arready = 1'b0;
				ar_wait = bus_delay();
				r_busy  = 1'b1;
				r_wait  = bus_delay();
				r_word  = mem[word_of(ar_addr)];
			end else if (arvalid && !arready) begin
				if (ar_wait == 0) begin
					arready = 1'b1;
				end else begin
					ar_wait--;
				end
			end
			// write response
			if (b_fire) begin
				bvalid = 1'b0;
				b_busy = 1'b0;
			end else if (b_busy && !bvalid) begin
				if (b_wait == 0) begin
					bvalid = 1'b1;
				end else begin
					b_wait--;
				end
			end
			// write address with data
			if (aw_fire) begin
				hits[2]++;
				hits[3]++;
				wr_count++;
				mem[word_of(aw_addr)] = aw_data;
				awready = 1'b0;
				aw_wait = bus_delay();
				b_busy  = 1'b1;
				b_wait  = bus_delay();
			end else if (awvalid && !awready) begin
				if (aw_wait == 0) begin
					awready = 1'b1;
				end else begin
					aw_wait--;
				end
			end
			// handshakes that the next rising edge completes
			ar_fire = arvalid && arready;
			ar_addr = araddr;
			r_fire  = rvalid && rready;
			aw_fire = awvalid && awready;
			aw_addr = awaddr;
			aw_data = wdata;
			b_fire  = bvalid && bready;
			rd_live = (rd_count < n_reads);
			if (rd_live) begin
				exp_araddr = rd_addr_q[rd_count];
				exp_rtest  = rd_test_q[rd_count];
			end
			wr_live = (wr_count < wr_addr_q.size());
			if (wr_live) begin
				exp_awaddr = wr_addr_q[wr_count];
				exp_wdata  = wr_data_q[wr_count];
			end
		end
	end

	// ----------------------------------------
	// value assertions
	// ----------------------------------------
	assert property (@(posedge clk) (rst_n && !$past(rst_n))
			|-> (io_stall && !arvalid && !awvalid && !rready && !bready))
		else begin
			errs[1]++;
			$display("FAIL reset io_stall=%h arvalid=%h awvalid=%h rready=%h bready=%h",
				$sampled(io_stall), $sampled(arvalid), $sampled(awvalid),
				$sampled(rready), $sampled(bready));
		end

	// fetch and load addresses in program order
	assert property (@(posedge clk) disable iff (!rst_n)
			(arvalid && arready && rd_live) |-> araddr == exp_araddr)
		else begin
			errs[exp_rtest]++;
			$display("FAIL araddr got %h expected %h", $sampled(araddr), exp_araddr);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
			(awvalid && awready && wr_live) |-> awaddr == exp_awaddr)
		else begin
			errs[3]++;
			$display("FAIL awaddr got %h expected %h", $sampled(awaddr), exp_awaddr);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
			(awvalid && awready && wr_live) |-> wdata == exp_wdata)
		else begin
			errs[2]++;
			$display("FAIL wdata got %h expected %h", $sampled(wdata), exp_wdata);
		end

	// every predicted store reached the bus
	assert property (@(posedge clk) end_check |-> wr_count == n_writes)
		else begin
			errs[2]++;
			$display("FAIL wr_count got %h expected %h", wr_count, n_writes);
		end

	assert property (@(posedge clk) end_check |-> stall_pulses == n_instr)
		else begin
			errs[6]++;
			$display("FAIL io_stall pulses got %h expected %h", stall_pulses, n_instr);
		end

	// ----------------------------------------
	// timeout and report
	// ----------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, program did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic print_report();
		int total_err;
		int total_hits;
		total_err = dut0.u_chk.fail_count;
		total_hits = 0;
		for (int t = 1; t <= 6; t++) begin
			if (hits[t] == 0) begin
				$display("test %0d %s: no check was reached", t, test_name(t));
				total_err++;
			end else begin
				$display("test %0d %s: %0d checks, %0d errors", t, test_name(t),
					hits[t], errs[t]);
			end
			total_hits += hits[t];
			total_err += errs[t];
		end
		$display("bus protocol assertions: %0d errors", dut0.u_chk.fail_count);
		$display("total: %0d checks, %0d errors", total_hits, total_err);
		if (total_err == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
	endtask

	initial begin
		rst_n   = 1'b0;
		arready = 1'b0;
		rdata   = '0;
		rvalid  = 1'b0;
		awready = 1'b0;
		bvalid  = 1'b0;
		for (int t = 1; t <= 6; t++) begin
			hits[t] = 0;
			errs[t] = 0;
		end
		lcg_state = 32'hfda35a98;
		load_program();
		build_trace();
		exp_araddr  = rd_addr_q[0];
		cycle_limit = 40 * n_instr * MAX_DELAY;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		// the reset property fires once on release
		hits[1]++;
		wait (rd_count == n_reads);
		@(negedge clk);
		end_check = 1'b1;
		hits[2]++;
		hits[6]++;
		@(negedge clk);
		end_check = 1'b0;
		@(negedge clk);
		print_report();
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_top.f */
rtl/cpu_isa_pkg.sv
rtl/cpu_mem_pkg.sv
rtl/mem_req_if.sv
rtl/cpu_control.sv
rtl/pc_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/bus_master.sv
rtl/cpu_top.sv
bench/cpu_top_assert.sv
bench/cpu_top_tb.sv
